// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ecc_88
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard src/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+src
src/ecc_pkg.sv
src/ecc_in_stage.sv
src/check_bit_tree.sv
src/ecc_correct.sv
src/ecc_88_top.sv
verif/ecc_checker.sv
verif/tb_ecc_88.sv

// File: src/check_bit_tree.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"
`default_nettype none

module check_bit_tree #(
    parameter int BIT = 0   // Which check bit this lane owns
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ecc_pkg::ecc_word_t stage1,
    output logic               check_bit,
    output logic               syn_bit
);

    // Data bits whose column has bit BIT set
    function automatic logic [`ECC_DATA_W-1:0] lane_mask();
        logic [`ECC_DATA_W-1:0]  m;
        logic [`ECC_CHECK_W-1:0] col;
        m = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            col  = ecc_pkg::column_of(i);
            m[i] = col[BIT];
        end
        return m;
    endfunction

    localparam logic [`ECC_DATA_W-1:0] MASK = lane_mask();

    logic recomputed;

    assign recomputed = ^(stage1.data & MASK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_bit <= 1'b0;
            syn_bit   <= 1'b0;
        end else begin
            check_bit <= recomputed;
            syn_bit   <= recomputed ^ stage1.check[BIT];   // Nonzero means a mismatch
        end
    end

    // The syndrome must line up with the check bit of the same word
    a_syn_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        syn_bit == (check_bit ^ $past(stage1.check[BIT]))
    );

endmodule

`default_nettype wire

// File: src/ecc_88_top.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"
`default_nettype none

module ecc_88_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    bypass,
    input  logic [`ECC_DATA_W-1:0]  data_in,
    input  logic [`ECC_CHECK_W-1:0] parity_in,
    output logic                    out_valid,
    output logic                    sbit_err,
    output logic                    dbit_err,
    output logic [`ECC_DATA_W-1:0]  data_out,
    output logic [`ECC_CHECK_W-1:0] parity_out
);

    ecc_pkg::ecc_word_t      stage1;
    logic                    stage1_valid;
    logic [`ECC_CHECK_W-1:0] syn_bits;
    logic [`ECC_CHECK_W-1:0] check_bits;   // Check bits recomputed from the data

    ecc_in_stage u_in_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .bypass       (bypass),
        .data_in      (data_in),
        .parity_in    (parity_in),
        .stage1       (stage1),
        .stage1_valid (stage1_valid)
    );

    // One lane per check bit
    for (genvar g = 0; g < `ECC_CHECK_W; g++) begin : g_lane
        check_bit_tree #(
            .BIT (g)
        ) u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .stage1    (stage1),
            .check_bit (check_bits[g]),
            .syn_bit   (syn_bits[g])
        );
    end

    ecc_correct u_correct (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage1       (stage1),
        .stage1_valid (stage1_valid),
        .syn_bits     (syn_bits),
        .check_bits   (check_bits),
        .out_valid    (out_valid),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .data_out     (data_out),
        .parity_out   (parity_out)
    );

endmodule

`default_nettype wire

// File: src/ecc_cfg.svh
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// Payload width of the protected word
`define ECC_DATA_W 88

// SEC-DED check bits, the top one is the overall parity
`define ECC_CHECK_W 8

// Edges from a sampled in_valid to the matching out_valid
`define ECC_LATENCY 3

`endif

// File: src/ecc_correct.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"
`default_nettype none

module ecc_correct (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ecc_pkg::ecc_word_t      stage1,
    input  logic                    stage1_valid,
    input  logic [`ECC_CHECK_W-1:0] syn_bits,
    input  logic [`ECC_CHECK_W-1:0] check_bits,
    output logic                    out_valid,
    output logic                    sbit_err,
    output logic                    dbit_err,
    output logic [`ECC_DATA_W-1:0]  data_out,
    output logic [`ECC_CHECK_W-1:0] parity_out
);

    ecc_pkg::ecc_word_t     stage2;         // Payload lined up with the lane outputs
    logic                   stage2_valid;
    ecc_pkg::syndrome_u     syn;
    logic [`ECC_DATA_W-1:0] flip;
    logic                   single_err;
    logic                   double_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage2 <= '0;
        end else if (stage1_valid) begin
            stage2 <= stage1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage2_valid <= 1'b0;
        end else begin
            stage2_valid <= stage1_valid;
        end
    end

    assign syn.raw = syn_bits;

    // Zero is clean, a single set bit is a bad check bit, a data column
    // names the bit to flip, and anything else is a double error
    always_comb begin
        logic [`ECC_CHECK_W-1:0] col;
        flip       = '0;
        single_err = 1'b0;
        double_err = 1'b0;
        col        = '0;
        if (syn.raw != '0) begin
            if ($onehot(syn.raw)) begin
                single_err = 1'b1;
            end else begin
                for (int i = 0; i < `ECC_DATA_W; i++) begin
                    col = ecc_pkg::column_of(i);
                    if (syn.fields.position == col[`ECC_CHECK_W-2:0] &&
                        syn.fields.overall == col[`ECC_CHECK_W-1]) begin
                        flip[i] = 1'b1;
                    end
                end
                single_err = |flip;
                double_err = ~|flip;   // Even weight or an unused position
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= stage2_valid;
            if (stage2_valid) begin
                sbit_err <= single_err & ~stage2.bypass;
                dbit_err <= double_err & ~stage2.bypass;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out   <= '0;
            parity_out <= '0;
        end else if (stage2_valid) begin
            data_out   <= stage2.bypass ? stage2.data : stage2.data ^ flip;
            parity_out <= check_bits;   // Encoding of the data as received
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(sbit_err && dbit_err)
    );

    a_bypass_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage2_valid && stage2.bypass) |=> (!sbit_err && !dbit_err)
    );

    // Counted from this stage, the first register is already behind us
    a_fixed_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(stage1_valid, `ECC_LATENCY - 1)
    );

endmodule

`default_nettype wire

// File: src/ecc_in_stage.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"
`default_nettype none

module ecc_in_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    bypass,
    input  logic [`ECC_DATA_W-1:0]  data_in,
    input  logic [`ECC_CHECK_W-1:0] parity_in,
    output ecc_pkg::ecc_word_t      stage1,
    output logic                    stage1_valid
);

    ecc_pkg::ecc_word_t word_d;

    assign word_d = '{data: data_in, check: parity_in, bypass: bypass};

    // The payload is only loaded on a strobe, so the lanes keep seeing the
    // last word while the input is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1 <= '0;
        end else if (in_valid) begin
            stage1 <= word_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= in_valid;
        end
    end

    // An X here would spread through every later valid stage
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(stage1_valid)
    );

endmodule

`default_nettype wire

// File: src/ecc_pkg.sv
`default_nettype none

`include "ecc_cfg.svh"

package ecc_pkg;

    // Everything the pipeline carries for one word
    typedef struct packed {
        logic [`ECC_DATA_W-1:0]  data;
        logic [`ECC_CHECK_W-1:0] check;   // Check bits as received
        logic                    bypass;
    } ecc_word_t;

    // The syndrome splits into the overall parity bit and a 7-bit position
    typedef struct packed {
        logic                    overall;
        logic [`ECC_CHECK_W-2:0] position;
    } syndrome_fields_t;

    typedef union packed {
        logic [`ECC_CHECK_W-1:0] raw;
        syndrome_fields_t        fields;
    } syndrome_u;

    // Check column of data bit i.
    // Data bit i sits at the i-th position from 3 upward that is not a power of
    // two, so the powers of two stay free for the check bits themselves.
    // The top bit is set when the position has even weight, which makes every
    // column odd weight and keeps double errors apart from single ones.
    function automatic logic [`ECC_CHECK_W-1:0] column_of(input int unsigned i);
        logic [`ECC_CHECK_W-2:0] pos;
        int unsigned             n;
        pos = '0;
        n   = 0;
        for (int unsigned p = 3; p < (1 << (`ECC_CHECK_W - 1)); p++) begin
            if ((p & (p - 1)) != 0) begin   // Skip powers of two
                if (n == i)
                    pos = p[`ECC_CHECK_W-2:0];
                n++;
            end
        end
        return {~^pos, pos};
    endfunction

endpackage

`default_nettype wire

// File: verif/ecc_checker.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"
`default_nettype none

module ecc_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    bypass,
    input  logic [`ECC_DATA_W-1:0]  data_in,
    input  logic                    out_valid,
    input  logic                    sbit_err,
    input  logic                    dbit_err,
    input  logic [`ECC_DATA_W-1:0]  data_out,
    input  logic [`ECC_CHECK_W-1:0] parity_out,
    input  logic [2:0]              kind,        // Error class the stimulus injected
    input  logic [2:0]              test_id,
    input  logic [`ECC_DATA_W-1:0]  orig_data,   // Word before any bit was flipped
    output int                      errors,
    output int                      checked,
    output logic                    idle
);

    typedef logic [`ECC_DATA_W-1:0] value_t;

    typedef struct packed {
        logic [`ECC_DATA_W-1:0]  data;
        logic [`ECC_CHECK_W-1:0] parity;
        logic                    sbit;
        logic                    dbit;
        logic [2:0]              test_id;
    } expect_t;

    expect_t                 pending[$];
    logic [`ECC_LATENCY-1:0] strobe_hist;
    int                      error_count = 0;
    int                      word_count = 0;
    bit                      drained = 1'b1;

    assign errors  = error_count;
    assign checked = word_count;
    assign idle    = drained;

    // Data bit n sits at the n-th position from 3 up that is not a power of two
    function automatic logic [`ECC_CHECK_W-1:0] column_for(input int bit_idx);
        int                      pos;
        int                      seen;
        logic [`ECC_CHECK_W-2:0] low;
        pos  = 2;
        seen = -1;
        while (seen < bit_idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0)
                seen++;
        end
        low = pos[`ECC_CHECK_W-2:0];
        return {~^low, low};   // Top bit makes the column odd weight
    endfunction

    function automatic logic [`ECC_CHECK_W-1:0] encode(input logic [`ECC_DATA_W-1:0] d);
        logic [`ECC_CHECK_W-1:0] c;
        c = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (d[i])
                c ^= column_for(i);
        end
        return c;
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "clean_word";
            3'd1:    return "data_bit_flip";
            3'd2:    return "check_bit_flip";
            3'd3:    return "double_flip";
            3'd4:    return "bypass";
            default: return "back_to_back";
        endcase
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input value_t expected, input value_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected %0h, actual %0h", name, field, expected, actual);
            error_count++;
        end
    endtask

    // Everything is sampled on the falling edge, half a cycle away from any change
    always @(negedge clk) begin
        expect_t exp_word;
        string   name;
        if (!rst_n) begin
            pending.delete();
            strobe_hist = '0;
            if (out_valid || sbit_err || dbit_err) begin
                $display("Outputs out_valid, sbit_err or dbit_err not low during reset at %0t",
                         $time);
                error_count++;
            end
        end else begin
            if (out_valid !== strobe_hist[`ECC_LATENCY-1]) begin
                $display("[FAIL] %s: out_valid expected %0b, actual %0b at %0t",
                         test_name(test_id), strobe_hist[`ECC_LATENCY-1], out_valid, $time);
                error_count++;
            end
            if (out_valid) begin
                if (pending.size() == 0) begin
                    $display("out_valid high at %0t with no word outstanding", $time);
                    error_count++;
                end else begin
                    exp_word = pending.pop_front();
                    name     = test_name(exp_word.test_id);
                    compare_field(name, "data_out", exp_word.data, data_out);
                    compare_field(name, "parity_out", value_t'(exp_word.parity),
                                  value_t'(parity_out));
                    compare_field(name, "sbit_err", value_t'(exp_word.sbit), value_t'(sbit_err));
                    compare_field(name, "dbit_err", value_t'(exp_word.dbit), value_t'(dbit_err));
                    word_count++;
                end
            end
            strobe_hist = {strobe_hist[`ECC_LATENCY-2:0], in_valid};
            if (in_valid) begin
                exp_word.data    = data_in;
                exp_word.parity  = encode(data_in);   // Encoding of the word as received
                exp_word.sbit    = 1'b0;
                exp_word.dbit    = 1'b0;
                exp_word.test_id = test_id;
                if (!bypass) begin
                    case (kind)
                        3'd0: exp_word.data = orig_data;
                        3'd1, 3'd2: begin
                            exp_word.data = orig_data;
                            exp_word.sbit = 1'b1;
                        end
                        default: exp_word.dbit = 1'b1;   // Received data stays as is
                    endcase
                end
                pending.push_back(exp_word);
            end
        end
        drained = (pending.size() == 0);
    end

endmodule

`default_nettype wire

// File: verif/tb_ecc_88.sv
`timescale 1ns/1ps
`include "ecc_cfg.svh"
`default_nettype none

module tb_ecc_88;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int TEST_WORDS   = 40;   // Per single error class
    localparam int B2B_WORDS    = 60;
    localparam int TOTAL_WORDS  = 5 * TEST_WORDS + B2B_WORDS;
    localparam int FLIP_SPAN    = `ECC_DATA_W + `ECC_CHECK_W;
    // A word takes at most two cycles and each of the six tests drains the pipeline
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * TOTAL_WORDS + 6 * (`ECC_LATENCY + 10) + 10;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    bypass;
    logic [`ECC_DATA_W-1:0]  data_in;
    logic [`ECC_CHECK_W-1:0] parity_in;
    logic                    out_valid;
    logic                    sbit_err;
    logic                    dbit_err;
    logic [`ECC_DATA_W-1:0]  data_out;
    logic [`ECC_CHECK_W-1:0] parity_out;
    logic [2:0]              kind;
    logic [2:0]              test_id;
    logic [`ECC_DATA_W-1:0]  orig_data;
    int                      errors;
    int                      checked;
    logic                    idle;
    logic [31:0]             rng_state;

    ecc_88_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .bypass     (bypass),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .out_valid  (out_valid),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .data_out   (data_out),
        .parity_out (parity_out)
    );

    ecc_checker chk0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .bypass     (bypass),
        .data_in    (data_in),
        .out_valid  (out_valid),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .data_out   (data_out),
        .parity_out (parity_out),
        .kind       (kind),
        .test_id    (test_id),
        .orig_data  (orig_data),
        .errors     (errors),
        .checked    (checked),
        .idle       (idle)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int random_below(input int n);
        return int'(next_random() % n);
    endfunction

    function automatic logic [`ECC_DATA_W-1:0] random_data();
        logic [95:0] r;
        r = {next_random(), next_random(), next_random()};
        return r[`ECC_DATA_W-1:0];
    endfunction

    // Bits 0 to 87 of the flip vector are data, the rest are check bits
    task automatic send_word(input logic [2:0] word_kind, input logic [2:0] tid);
        logic [`ECC_DATA_W-1:0] orig;
        logic [FLIP_SPAN-1:0]   bits;
        int                     first;
        int                     second;
        int                     flips;
        orig = random_data();
        bits = {chk0.encode(orig), orig};
        case (word_kind)
            3'd1: begin
                first       = random_below(`ECC_DATA_W);
                bits[first] = ~bits[first];
            end
            3'd2: begin
                first       = `ECC_DATA_W + random_below(`ECC_CHECK_W);
                bits[first] = ~bits[first];
            end
            3'd3: begin
                first        = random_below(FLIP_SPAN);
                second       = (first + 1 + random_below(FLIP_SPAN - 1)) % FLIP_SPAN;
                bits[first]  = ~bits[first];
                bits[second] = ~bits[second];
            end
            3'd4: begin
                flips = random_below(3);
                for (int k = 0; k < flips; k++) begin
                    first       = random_below(FLIP_SPAN);
                    bits[first] = ~bits[first];
                end
            end
            default: ;
        endcase
        @(posedge clk);
        #2;
        in_valid  = 1'b1;
        bypass    = (word_kind == 3'd4);
        data_in   = bits[`ECC_DATA_W-1:0];
        parity_in = bits[FLIP_SPAN-1:`ECC_DATA_W];
        kind      = word_kind;
        test_id   = tid;
        orig_data = orig;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        bypass   = 1'b0;
    endtask

    task automatic run_test(input logic [2:0] tid, input int words, input bit with_gaps);
        int         errors_before;
        logic [2:0] word_kind;
        errors_before = errors;
        for (int n = 0; n < words; n++) begin
            word_kind = (tid == 3'd5) ? 3'(random_below(5)) : tid;   // Mixed classes
            send_word(word_kind, tid);
            if (with_gaps && random_below(2) == 1)
                idle_cycle();
        end
        idle_cycle();
        do @(posedge clk); while (!idle);
        $display("test %-15s %0d words, %0d errors", chk0.test_name(tid), words,
                 errors - errors_before);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        bypass    = 1'b0;
        data_in   = '0;
        parity_in = '0;
        kind      = '0;
        test_id   = '0;
        orig_data = '0;
        rng_state = 32'd9;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int t = 0; t < 5; t++) begin
            run_test(3'(t), TEST_WORDS, 1'b1);
        end
        run_test(3'd5, B2B_WORDS, 1'b0);
        $display("words checked %0d of %0d, errors %0d", checked, TOTAL_WORDS, errors);
        if (errors == 0 && checked == TOTAL_WORDS) begin
            $display("** PASS **");
        end else begin
            if (checked != TOTAL_WORDS)
                $display("Not every word sent came back out of the DUT");
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped returning words",
                 RUN_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
